/* logic/stap_pkg.sv */
`default_nettype none

package stap_pkg;

    // TAP controller states, standard 1149.1 encoding
    typedef enum logic [3:0] {
        ST_EXIT2_DR   = 4'h0,
        ST_EXIT1_DR   = 4'h1,
        ST_SHIFT_DR   = 4'h2,
        ST_PAUSE_DR   = 4'h3,
        ST_SELECT_IR  = 4'h4,
        ST_UPDATE_DR  = 4'h5,
        ST_CAPTURE_DR = 4'h6,
        ST_SELECT_DR  = 4'h7,
        ST_EXIT2_IR   = 4'h8,
        ST_EXIT1_IR   = 4'h9,
        ST_SHIFT_IR   = 4'hA,
        ST_PAUSE_IR   = 4'hB,
        ST_RTI        = 4'hC,
        ST_UPDATE_IR  = 4'hD,
        ST_CAPTURE_IR = 4'hE,
        ST_TLR        = 4'hF
    } stap_state_e;

    localparam int STAP_IR_WIDTH  = 8;
    localparam int STAP_TDR_WIDTH = 32;
    localparam int STAP_TDR_COUNT = 2;

    // Public opcodes
    localparam logic [STAP_IR_WIDTH-1:0] STAP_OPC_IDCODE = 8'h0C;
    localparam logic [STAP_IR_WIDTH-1:0] STAP_OPC_BYPASS = 8'hFF;
    // Fixed IR capture pattern, LSBs 01 per 1149.1
    localparam logic [STAP_IR_WIDTH-1:0] STAP_IR_CAPTURE = 8'h01;

    //------------------------------------------------------------
    // Instruction word, two decodings of the same 8 bits
    //------------------------------------------------------------
    typedef struct packed {
        logic       kind;
        logic [6:0] opcode;
    } stap_ir_public_t;

    // Kind 1, level needed plus register index
    typedef struct packed {
        logic       kind;
        logic [2:0] level;
        logic [3:0] index;
    } stap_ir_remote_t;

    typedef union packed {
        stap_ir_public_t public_view;
        stap_ir_remote_t remote_view;
    } stap_ir_u;

    // Per-state strobes from the controller
    typedef struct packed {
        logic test_logic_reset;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
    } stap_ctrl_t;

    // Data register currently in the scan path
    typedef enum logic [1:0] {
        SEL_BYPASS = 2'd0,
        SEL_IDCODE = 2'd1,
        SEL_TDR0   = 2'd2,
        SEL_TDR1   = 2'd3
    } stap_sel_e;

endpackage

`default_nettype wire

/* logic/stap_security_pkg.sv */
`default_nettype none

package stap_security_pkg;

    // Policy codes from the security fuse controller
    typedef enum logic [3:0] {
        POLICY_LOCKED        = 4'h0,
        POLICY_RED           = 4'h2,
        POLICY_FUNCTIONALITY = 4'h4,
        POLICY_OEM_UNLOCKED  = 4'h5
    } stap_policy_e;

    // Full access while still in early boot
    localparam logic [2:0] STAP_LEVEL_MAX = 3'd7;

    //------------------------------------------------------------
    // Policy to access level table
    //------------------------------------------------------------
    function automatic logic [2:0] policy_level(stap_policy_e policy);
        case (policy)
            POLICY_LOCKED:        return 3'd0;
            POLICY_FUNCTIONALITY: return 3'd2;
            POLICY_OEM_UNLOCKED:  return 3'd5;
            POLICY_RED:           return 3'd7;
            // Unknown codes fall back to locked
            default:              return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/stap_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module stap_fsm (
    input  wire                     tck,
    input  wire                     rst_n,
    input  logic                    tms,
    output stap_pkg::stap_state_e   state,
    output stap_pkg::stap_ctrl_t    ctrl
);

    stap_pkg::stap_state_e next_state;

    //------------------------------------------------------------
    // State register
    //------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            state <= stap_pkg::ST_TLR;
        end else begin
            state <= next_state;
        end
    end

    // Standard transition table, tms sampled on every rising edge
    always_comb begin
        next_state = state;
        case (state)
            stap_pkg::ST_TLR:        next_state = tms ? stap_pkg::ST_TLR : stap_pkg::ST_RTI;
            stap_pkg::ST_RTI:        next_state = tms ? stap_pkg::ST_SELECT_DR : stap_pkg::ST_RTI;
            // Data column
            stap_pkg::ST_SELECT_DR:  next_state = tms ? stap_pkg::ST_SELECT_IR
                                                      : stap_pkg::ST_CAPTURE_DR;
            stap_pkg::ST_CAPTURE_DR: next_state = tms ? stap_pkg::ST_EXIT1_DR : stap_pkg::ST_SHIFT_DR;
            stap_pkg::ST_SHIFT_DR:   next_state = tms ? stap_pkg::ST_EXIT1_DR : stap_pkg::ST_SHIFT_DR;
            stap_pkg::ST_EXIT1_DR:   next_state = tms ? stap_pkg::ST_UPDATE_DR : stap_pkg::ST_PAUSE_DR;
            stap_pkg::ST_PAUSE_DR:   next_state = tms ? stap_pkg::ST_EXIT2_DR : stap_pkg::ST_PAUSE_DR;
            stap_pkg::ST_EXIT2_DR:   next_state = tms ? stap_pkg::ST_UPDATE_DR : stap_pkg::ST_SHIFT_DR;
            stap_pkg::ST_UPDATE_DR:  next_state = tms ? stap_pkg::ST_SELECT_DR : stap_pkg::ST_RTI;
            // Instruction column
            stap_pkg::ST_SELECT_IR:  next_state = tms ? stap_pkg::ST_TLR : stap_pkg::ST_CAPTURE_IR;
            stap_pkg::ST_CAPTURE_IR: next_state = tms ? stap_pkg::ST_EXIT1_IR : stap_pkg::ST_SHIFT_IR;
            stap_pkg::ST_SHIFT_IR:   next_state = tms ? stap_pkg::ST_EXIT1_IR : stap_pkg::ST_SHIFT_IR;
            stap_pkg::ST_EXIT1_IR:   next_state = tms ? stap_pkg::ST_UPDATE_IR : stap_pkg::ST_PAUSE_IR;
            stap_pkg::ST_PAUSE_IR:   next_state = tms ? stap_pkg::ST_EXIT2_IR : stap_pkg::ST_PAUSE_IR;
            stap_pkg::ST_EXIT2_IR:   next_state = tms ? stap_pkg::ST_UPDATE_IR : stap_pkg::ST_SHIFT_IR;
            stap_pkg::ST_UPDATE_IR:  next_state = tms ? stap_pkg::ST_SELECT_DR : stap_pkg::ST_RTI;
            default:                 next_state = stap_pkg::ST_TLR;
        endcase
    end

    //------------------------------------------------------------
    // Strobes follow the current state
    //------------------------------------------------------------
    always_comb begin
        // Held in reset counts as Test-Logic-Reset
        ctrl.test_logic_reset = !rst_n || (state == stap_pkg::ST_TLR);
        ctrl.capture_ir       = (state == stap_pkg::ST_CAPTURE_IR);
        ctrl.shift_ir         = (state == stap_pkg::ST_SHIFT_IR);
        ctrl.update_ir        = (state == stap_pkg::ST_UPDATE_IR);
        ctrl.capture_dr       = (state == stap_pkg::ST_CAPTURE_DR);
        ctrl.shift_dr         = (state == stap_pkg::ST_SHIFT_DR);
        ctrl.update_dr        = (state == stap_pkg::ST_UPDATE_DR);
    end

endmodule

`default_nettype wire

/* logic/stap_ir_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module stap_ir_decode (
    input  wire                                 tck,
    input  wire                                 rst_n,
    input  logic                                tdi,
    input  stap_pkg::stap_ctrl_t                ctrl,
    input  stap_security_pkg::stap_policy_e     secure_policy,
    input  logic                                policy_update,
    input  logic                                earlyboot_exit,
    output stap_pkg::stap_sel_e                 sel,
    output logic                                ir_tdo
);

    logic [stap_pkg::STAP_IR_WIDTH-1:0] ir_shift;
    stap_pkg::stap_ir_u                 ir_upd;
    stap_security_pkg::stap_policy_e    policy_q;
    logic [2:0]                         eff_level;

    //------------------------------------------------------------
    // IR shift stage
    //------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (ctrl.capture_ir) begin
            ir_shift <= stap_pkg::STAP_IR_CAPTURE;
        end else if (ctrl.shift_ir) begin
            // tdi enters at the MSB, LSB leaves first
            ir_shift <= {tdi, ir_shift[stap_pkg::STAP_IR_WIDTH-1:1]};
        end
    end

    assign ir_tdo = ir_shift[0];

    // Update stage, IDCODE on reset and in Test-Logic-Reset
    always_ff @(posedge tck) begin
        if (!rst_n || ctrl.test_logic_reset) begin
            ir_upd <= stap_pkg::STAP_OPC_IDCODE;
        end else if (ctrl.update_ir) begin
            ir_upd <= ir_shift;
        end
    end

    //------------------------------------------------------------
    // Security policy latch
    //------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            policy_q <= stap_security_pkg::POLICY_LOCKED;
        end else if (policy_update) begin
            policy_q <= secure_policy;
        end
    end

    // Early boot grants everything
    assign eff_level = earlyboot_exit ? stap_security_pkg::policy_level(policy_q)
                                      : stap_security_pkg::STAP_LEVEL_MAX;

    // Decode, re-evaluated each cycle so a policy change is seen at once
    always_comb begin
        sel = stap_pkg::SEL_BYPASS;
        if (ir_upd.remote_view.kind) begin
            // Remote view, index must exist and level must be granted
            // BYPASS opcode carries index 15 and falls through to bypass
            if ((int'(ir_upd.remote_view.index) < stap_pkg::STAP_TDR_COUNT) &&
                (ir_upd.remote_view.level <= eff_level)) begin
                sel = ir_upd.remote_view.index[0] ? stap_pkg::SEL_TDR1 : stap_pkg::SEL_TDR0;
            end
        end else if (ir_upd.public_view.opcode == stap_pkg::STAP_OPC_IDCODE[6:0]) begin
            sel = stap_pkg::SEL_IDCODE;
        end
        // Other public opcodes stay on bypass
    end

endmodule

`default_nettype wire

/* logic/stap_tdr_bank.sv */
`default_nettype none
`timescale 1ns/1ps

module stap_tdr_bank (
    input  wire                     tck,
    input  wire                     rst_n,
    input  logic                    tdi,
    input  stap_pkg::stap_ctrl_t    ctrl,
    input  stap_pkg::stap_sel_e     sel,
    input  logic [stap_pkg::STAP_TDR_WIDTH-1:0] slvidcode,
    input  logic [stap_pkg::STAP_TDR_COUNT*stap_pkg::STAP_TDR_WIDTH-1:0] tdr_data_in,
    output logic [stap_pkg::STAP_TDR_COUNT*stap_pkg::STAP_TDR_WIDTH-1:0] tdr_data_out,
    output logic                    dr_tdo
);

    // Parallel ports viewed as word arrays
    logic [stap_pkg::STAP_TDR_COUNT-1:0][stap_pkg::STAP_TDR_WIDTH-1:0] data_in_w;
    logic [stap_pkg::STAP_TDR_COUNT-1:0][stap_pkg::STAP_TDR_WIDTH-1:0] data_out_q;

    logic [stap_pkg::STAP_TDR_WIDTH-1:0] dr_shift;
    logic [stap_pkg::STAP_TDR_WIDTH-1:0] cap_val;
    logic                                bypass_q;
    logic                                tdr_hit;
    logic                                tdr_idx;

    assign data_in_w    = tdr_data_in;
    assign tdr_data_out = data_out_q;

    // Remote selections, low sel bit names the word
    assign tdr_hit = (sel == stap_pkg::SEL_TDR0) || (sel == stap_pkg::SEL_TDR1);
    assign tdr_idx = sel[0];

    //------------------------------------------------------------
    // Capture value for the selected path
    //------------------------------------------------------------
    always_comb begin
        if (tdr_hit) begin
            cap_val = data_in_w[tdr_idx];
        end else if (sel == stap_pkg::SEL_IDCODE) begin
            // IDCODE LSB is always 1
            cap_val = {slvidcode[stap_pkg::STAP_TDR_WIDTH-1:1], 1'b1};
        end else begin
            cap_val = '0;
        end
    end

    // Shared 32-bit shift path for IDCODE and both TDRs
    always_ff @(posedge tck) begin
        if (ctrl.capture_dr) begin
            dr_shift <= cap_val;
        end else if (ctrl.shift_dr) begin
            dr_shift <= {tdi, dr_shift[stap_pkg::STAP_TDR_WIDTH-1:1]};
        end
    end

    // One-bit bypass stage
    always_ff @(posedge tck) begin
        if (ctrl.capture_dr) begin
            bypass_q <= 1'b0;
        end else if (ctrl.shift_dr) begin
            bypass_q <= tdi;
        end
    end

    assign dr_tdo = (sel == stap_pkg::SEL_BYPASS) ? bypass_q : dr_shift[0];

    //------------------------------------------------------------
    // Update registers, one per remote word
    //------------------------------------------------------------
    for (genvar n = 0; n < stap_pkg::STAP_TDR_COUNT; n++) begin : g_tdr
        always_ff @(posedge tck) begin
            if (!rst_n) begin
                data_out_q[n] <= '0;
            end else if (ctrl.update_dr && tdr_hit && (int'(tdr_idx) == n)) begin
                // Only the addressed word moves
                data_out_q[n] <= dr_shift;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/stap_tdo_mux.sv */
`default_nettype none
`timescale 1ns/1ps

module stap_tdo_mux (
    input  stap_pkg::stap_state_e   state,
    input  logic                    ir_tdo,
    input  logic                    dr_tdo,
    output logic                    tdo,
    output logic                    tdo_en
);

    //------------------------------------------------------------
    // Serial output select
    //------------------------------------------------------------
    always_comb begin
        case (state)
            stap_pkg::ST_SHIFT_IR: begin
                // IR path
                tdo    = ir_tdo;
                tdo_en = 1'b1;
            end
            stap_pkg::ST_SHIFT_DR: begin
                // Selected data register path
                tdo    = dr_tdo;
                tdo_en = 1'b1;
            end
            default: begin
                // Quiet outside shift states
                tdo    = 1'b0;
                tdo_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/stap_top.sv */
`default_nettype none
`timescale 1ns/1ps

module stap_top (
    input  wire                                 tck,
    input  wire                                 rst_n,
    input  logic                                tms,
    input  logic                                tdi,
    input  logic [31:0]                         slvidcode,
    input  stap_security_pkg::stap_policy_e     secure_policy,
    input  logic                                policy_update,
    input  logic                                earlyboot_exit,
    input  logic [63:0]                         tdr_data_in,
    output logic                                tdo,
    output logic                                tdo_en,
    output logic [63:0]                         tdr_data_out
);

    stap_pkg::stap_state_e  state;
    stap_pkg::stap_ctrl_t   ctrl;
    stap_pkg::stap_sel_e    sel;
    logic                   ir_tdo;
    logic                   dr_tdo;

    //------------------------------------------------------------
    // Controller and instruction decode
    //------------------------------------------------------------
    stap_fsm i_stap_fsm (
        .tck   (tck),
        .rst_n (rst_n),
        .tms   (tms),
        .state (state),
        .ctrl  (ctrl)
    );

    stap_ir_decode i_stap_ir_decode (
        .tck            (tck),
        .rst_n          (rst_n),
        .tdi            (tdi),
        .ctrl           (ctrl),
        .secure_policy  (secure_policy),
        .policy_update  (policy_update),
        .earlyboot_exit (earlyboot_exit),
        .sel            (sel),
        .ir_tdo         (ir_tdo)
    );

    // Data registers and serial output
    stap_tdr_bank i_stap_tdr_bank (
        .tck          (tck),
        .rst_n        (rst_n),
        .tdi          (tdi),
        .ctrl         (ctrl),
        .sel          (sel),
        .slvidcode    (slvidcode),
        .tdr_data_in  (tdr_data_in),
        .tdr_data_out (tdr_data_out),
        .dr_tdo       (dr_tdo)
    );

    stap_tdo_mux i_stap_tdo_mux (
        .state  (state),
        .ir_tdo (ir_tdo),
        .dr_tdo (dr_tdo),
        .tdo    (tdo),
        .tdo_en (tdo_en)
    );

endmodule

`default_nettype wire

/* verif/stap_tb_tests.svh */
//------------------------------------------------------------
// JTAG host side
//------------------------------------------------------------

// One tck cycle, tdo sampled in the state that consumes tms/tdi
task automatic tap_cycle(input logic tms_val, input logic tdi_val, input logic en_exp,
                         output logic tdo_val);
    @(posedge tck);
    tms <= tms_val;
    tdi <= tdi_val;
    @(negedge tck);
    check_value("tdo_en", {63'b0, tdo_en}, {63'b0, en_exp});
    // Output quiet whenever not shifting
    if (!en_exp) check_value("tdo", {63'b0, tdo}, 64'd0);
    tdo_val = tdo;
endtask

// Full scan from Run-Test/Idle back to Run-Test/Idle, LSB first
task automatic scan_path(input logic is_ir, input int nbits, input logic [63:0] din,
                         output logic [63:0] dout);
    logic o;
    dout = '0;
    tap_cycle(1'b1, 1'b0, 1'b0, o);
    if (is_ir) tap_cycle(1'b1, 1'b0, 1'b0, o);
    tap_cycle(1'b0, 1'b0, 1'b0, o);
    tap_cycle(1'b0, 1'b0, 1'b0, o);
    for (int i = 0; i < nbits; i++) begin
        tap_cycle(i == nbits - 1, din[i], 1'b1, o);
        dout[i] = o;
    end
    // Exit1, Update, then one idle cycle so the update edge has passed
    tap_cycle(1'b1, 1'b0, 1'b0, o);
    tap_cycle(1'b0, 1'b0, 1'b0, o);
    tap_cycle(1'b0, 1'b0, 1'b0, o);
endtask

//------------------------------------------------------------
// Reference model
//------------------------------------------------------------
function automatic logic [2:0] level_of(input stap_security_pkg::stap_policy_e pol);
    case (pol)
        stap_security_pkg::POLICY_FUNCTIONALITY: return 3'd2;
        stap_security_pkg::POLICY_OEM_UNLOCKED:  return 3'd5;
        stap_security_pkg::POLICY_RED:           return 3'd7;
        default:                                 return 3'd0;
    endcase
endfunction

function automatic int select_path(input logic [7:0] ir,
                                   input stap_security_pkg::stap_policy_e pol,
                                   input logic eb_exit);
    logic [2:0] granted;
    granted = eb_exit ? level_of(pol) : 3'd7;
    if (ir == 8'hFF) return PATH_BYPASS;
    if (ir[7]) begin
        // Remote, index 0 or 1 and level within the grant
        if ((ir[3:0] < 4'd2) && (ir[6:4] <= granted)) return ir[0] ? PATH_TDR1 : PATH_TDR0;
        return PATH_BYPASS;
    end
    return (ir[6:0] == 7'h0C) ? PATH_IDCODE : PATH_BYPASS;
endfunction

// Captured bits leave first, then the bits shifted in
function automatic logic [63:0] expect_dr(input logic [7:0] ir,
                                          input stap_security_pkg::stap_policy_e pol,
                                          input logic eb_exit, input logic [31:0] idcode,
                                          input logic [63:0] data_in, input logic [63:0] din,
                                          input int nbits);
    logic [63:0] cap;
    logic [63:0] result;
    int          len;
    len = 32;
    case (select_path(ir, pol, eb_exit))
        PATH_IDCODE: cap = {32'b0, idcode[31:1], 1'b1};
        PATH_TDR0:   cap = {32'b0, data_in[31:0]};
        PATH_TDR1:   cap = {32'b0, data_in[63:32]};
        default: begin
            cap = '0;
            len = 1;
        end
    endcase
    result = (din << len) | cap;
    if (nbits < 64) result = result & ((64'd1 << nbits) - 64'd1);
    return result;
endfunction

//------------------------------------------------------------
// Scan helpers with checks
//------------------------------------------------------------
task automatic ir_load(input logic [7:0] instr);
    logic [63:0] got;
    scan_path(1'b1, 8, {56'b0, instr}, got);
    check_value("tdo", got, 64'h01);
    ir_model = instr;
endtask

task automatic dr_check(input int nbits, input logic [63:0] din);
    logic [63:0] exp;
    logic [63:0] got;
    int          path;
    exp  = expect_dr(ir_model, pol_model, earlyboot_exit, slvidcode, tdr_data_in, din, nbits);
    path = select_path(ir_model, pol_model, earlyboot_exit);
    scan_path(1'b0, nbits, din, got);
    check_value("tdo", got, exp);
    // Only the addressed word takes the shifted value
    if (path == PATH_TDR0) out_model[31:0] = din[31:0];
    if (path == PATH_TDR1) out_model[63:32] = din[31:0];
    check_value("tdr_data_out", tdr_data_out, out_model);
endtask

task automatic drive_words(input logic [31:0] idcode, input logic [63:0] data);
    @(posedge tck);
    slvidcode   <= idcode;
    tdr_data_in <= data;
    @(negedge tck);
endtask

task automatic set_earlyboot(input logic value);
    @(posedge tck);
    earlyboot_exit <= value;
    @(negedge tck);
endtask

task automatic set_policy(input stap_security_pkg::stap_policy_e pol);
    @(posedge tck);
    secure_policy <= pol;
    policy_update <= 1'b1;
    @(posedge tck);
    policy_update <= 1'b0;
    @(negedge tck);
    pol_model = pol;
endtask

//------------------------------------------------------------
// Tests
//------------------------------------------------------------
// 1: IDCODE selected straight after reset
task automatic test_reset_idcode();
    logic o;
    tap_cycle(1'b0, 1'b0, 1'b0, o);
    dr_check(32, {32'b0, $urandom()});
endtask

// 2: IR capture pattern, then BYPASS one-bit delay
task automatic test_ir_capture();
    logic [63:0] got;
    logic [7:0]  pad;
    pad = 8'($urandom());
    scan_path(1'b1, 16, {48'b0, stap_pkg::STAP_OPC_BYPASS, pad}, got);
    check_value("tdo", got, {48'b0, pad, 8'h01});
    ir_model = stap_pkg::STAP_OPC_BYPASS;
    dr_check(16, {48'b0, 16'($urandom())});
endtask

// 3: writes to both remote words
task automatic test_remote_write();
    drive_words($urandom(), {$urandom(), $urandom()});
    ir_load(8'h80);
    dr_check(32, {32'b0, $urandom()});
    ir_load(8'hF1);
    dr_check(32, {32'b0, $urandom()});
endtask

// 4: parallel words captured and scanned out
task automatic test_parallel_capture();
    drive_words(slvidcode, {$urandom(), $urandom()});
    ir_load(8'h81);
    dr_check(32, {32'b0, $urandom()});
    ir_load(8'hA0);
    dr_check(32, {32'b0, $urandom()});
endtask

// 5: locked policy turns high-level remote access into bypass
task automatic test_policy_gating();
    set_earlyboot(1'b1);
    set_policy(stap_security_pkg::POLICY_LOCKED);
    ir_load(8'hB0);
    dr_check(32, {32'b0, $urandom()});
    ir_load(8'h80);
    dr_check(32, {32'b0, $urandom()});
    ir_load(8'hD1);
    dr_check(32, {32'b0, $urandom()});
    set_policy(stap_security_pkg::POLICY_RED);
    dr_check(32, {32'b0, $urandom()});
    set_policy(stap_security_pkg::POLICY_FUNCTIONALITY);
    dr_check(32, {32'b0, $urandom()});
endtask

// 6: five tms-high clocks bring back IDCODE
task automatic test_tms_reset();
    logic o;
    ir_load(8'h81);
    repeat (5) tap_cycle(1'b1, 1'b0, 1'b0, o);
    tap_cycle(1'b0, 1'b0, 1'b0, o);
    ir_model = stap_pkg::STAP_OPC_IDCODE;
    dr_check(32, {32'b0, $urandom()});
endtask

/* verif/stap_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module stap_tb;

    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 2000;

    // Scan path seen by the host model
    localparam int PATH_BYPASS = 0;
    localparam int PATH_IDCODE = 1;
    localparam int PATH_TDR0   = 2;
    localparam int PATH_TDR1   = 3;

    logic                            tck = 1'b0;
    logic                            rst_n;
    logic                            tms;
    logic                            tdi;
    logic [31:0]                     slvidcode;
    stap_security_pkg::stap_policy_e secure_policy;
    logic                            policy_update;
    logic                            earlyboot_exit;
    logic [63:0]                     tdr_data_in;
    logic                            tdo;
    logic                            tdo_en;
    logic [63:0]                     tdr_data_out;

    // Host-side view of instruction, policy and parallel outputs
    logic [7:0]                      ir_model;
    stap_security_pkg::stap_policy_e pol_model;
    logic [63:0]                     out_model;

    // 10 ns test clock
    always #5 tck = ~tck;

    stap_top UUT (
        .tck            (tck),
        .rst_n          (rst_n),
        .tms            (tms),
        .tdi            (tdi),
        .slvidcode      (slvidcode),
        .secure_policy  (secure_policy),
        .policy_update  (policy_update),
        .earlyboot_exit (earlyboot_exit),
        .tdr_data_in    (tdr_data_in),
        .tdo            (tdo),
        .tdo_en         (tdo_en),
        .tdr_data_out   (tdr_data_out)
    );

    //------------------------------------------------------------
    // Compare one value against its expected value
    //------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    `include "stap_tb_tests.svh"

    // Watchdog, budget scales with the number of tests
    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge tck);
        $display("timeout: tests did not finish within %0d cycles",
                 TEST_COUNT * CYCLES_PER_TEST);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    //------------------------------------------------------------
    // Run sequence
    //------------------------------------------------------------
    initial begin
        void'($urandom(32'hcb2d));
        // All DUT inputs start defined, tms high keeps the TAP in reset
        rst_n          <= 1'b0;
        tms            <= 1'b1;
        tdi            <= 1'b0;
        slvidcode      <= $urandom();
        secure_policy  <= stap_security_pkg::POLICY_LOCKED;
        policy_update  <= 1'b0;
        earlyboot_exit <= 1'b0;
        tdr_data_in    <= '0;
        ir_model  = stap_pkg::STAP_OPC_IDCODE;
        pol_model = stap_security_pkg::POLICY_LOCKED;
        out_model = '0;
        // Reset held for 5 cycles
        repeat (5) @(posedge tck);
        rst_n <= 1'b1;

        test_reset_idcode();
        test_ir_capture();
        test_remote_write();
        test_parallel_capture();
        test_policy_gating();
        test_tms_reset();

        // Any mismatch has already stopped the run
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* stap_top.f */
+incdir+verif
logic/stap_pkg.sv
logic/stap_security_pkg.sv
logic/stap_fsm.sv
logic/stap_ir_decode.sv
logic/stap_tdr_bank.sv
logic/stap_tdo_mux.sv
logic/stap_top.sv
verif/stap_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module stap_tb \
		-f stap_top.f -Mdir obj_dir -o stap_sim
	./obj_dir/stap_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
